// ==== hw/serial_bus_pkg.sv ====
package serial_bus_pkg;

    localparam int SLAVE_ID_WIDTH = 2;
    // cycles a master waits for an acknowledge or a read start bit.
    localparam int ACK_WINDOW = 16;

    typedef enum logic [3:0] {
        s_idle,
        s_id_match,
        s_wait_peer,
        s_addr_rx,
        s_addr_ack,
        s_data_rx,
        s_data_ack,
        s_mem_write_wait,
        s_mem_read_wait,
        s_data_tx,
        s_cleanup
    } slave_state_e;

    typedef enum logic [3:0] {
        m_idle,
        m_wait_grant,
        m_send_header,
        m_send_addr,
        m_wait_addr_ack,
        m_send_data,
        m_wait_data_ack,
        m_wait_read_start,
        m_receive_data,
        m_finish
    } master_state_e;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } bus_op_e;

endpackage

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic       clk,
    input  logic       rstn,
    input  logic [1:0] bus_req,
    output logic [1:0] grant,
    output logic       bus_util
);

    // index of the master that held the bus last.
    logic last_served;

    assign bus_util = |grant;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            grant       <= 2'b00;
            last_served <= 1'b1;
        end else if (grant == 2'b00) begin
            if (bus_req == 2'b11) begin
                grant       <= last_served ? 2'b01 : 2'b10;
                last_served <= !last_served;
            end else if (bus_req[0]) begin
                grant       <= 2'b01;
                last_served <= 1'b0;
            end else if (bus_req[1]) begin
                grant       <= 2'b10;
                last_served <= 1'b1;
            end
        end else if ((grant & bus_req) == 2'b00) begin
            // holder is done, the line is free for one cycle.
            grant <= 2'b00;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) $onehot0(grant))
        else $error("bus_arbiter: more than one grant");

    assert property (@(posedge clk) disable iff (!rstn)
        |(grant & bus_req) |=> grant == $past(grant))
        else $error("bus_arbiter: grant moved while the holder still requests");

endmodule

// ==== hw/bus_master.sv ====
`timescale 1ns/1ps

module bus_master #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 8
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      req,
    input  logic                                      req_write,
    input  logic [serial_bus_pkg::SLAVE_ID_WIDTH-1:0] req_slave_id,
    input  logic [ADDR_WIDTH-1:0]                     req_addr,
    input  logic [DATA_WIDTH-1:0]                     req_wdata,
    input  logic                                      grant,
    input  logic                                      bus_in,
    output logic                                      busy,
    output logic                                      bus_req,
    output logic                                      bus_out,
    output logic                                      done,
    output logic [DATA_WIDTH-1:0]                     rdata,
    output logic                                      nack
);

    localparam int HDR_W = serial_bus_pkg::SLAVE_ID_WIDTH + 1 + ADDR_WIDTH;
    localparam int MAX_W = (ADDR_WIDTH > DATA_WIDTH) ? ADDR_WIDTH : DATA_WIDTH;
    localparam int CNT_W = $clog2(MAX_W + 1);
    localparam int WIN_W = $clog2(serial_bus_pkg::ACK_WINDOW + 1);

    serial_bus_pkg::master_state_e state;
    serial_bus_pkg::bus_op_e       op;
    logic [HDR_W-1:0]      hdr_sh;
    logic [DATA_WIDTH-1:0] data_sh;
    logic [CNT_W-1:0]      bit_cnt;
    logic [WIN_W-1:0]      wait_cnt;
    logic                  prev_low;
    logic                  ack_seen;
    logic                  timeout;

    // an acknowledge is two low samples in a row.
    assign ack_seen = prev_low && !bus_in;
    assign timeout  = wait_cnt == WIN_W'(serial_bus_pkg::ACK_WINDOW - 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= serial_bus_pkg::m_idle;
            op       <= serial_bus_pkg::op_read;
            busy     <= 1'b0;
            bus_req  <= 1'b0;
            bus_out  <= 1'b1;
            done     <= 1'b0;
            nack     <= 1'b0;
            rdata    <= '0;
            bit_cnt  <= '0;
            wait_cnt <= '0;
            prev_low <= 1'b0;
        end else begin
            done     <= 1'b0;
            wait_cnt <= '0;
            prev_low <= 1'b0;
            case (state)
                serial_bus_pkg::m_idle: begin
                    if (req) begin
                        busy    <= 1'b1;
                        bus_req <= 1'b1;
                        nack    <= 1'b0;
                        op      <= serial_bus_pkg::bus_op_e'(req_write);
                        hdr_sh  <= {req_slave_id, req_write, req_addr};
                        data_sh <= req_wdata;
                        state   <= serial_bus_pkg::m_wait_grant;
                    end
                end
                serial_bus_pkg::m_wait_grant: begin
                    if (grant) begin
                        // start bit.
                        bus_out <= 1'b0;
                        bit_cnt <= CNT_W'(serial_bus_pkg::SLAVE_ID_WIDTH);
                        state   <= serial_bus_pkg::m_send_header;
                    end
                end
                serial_bus_pkg::m_send_header: begin
                    bus_out <= hdr_sh[HDR_W-1];
                    hdr_sh  <= hdr_sh << 1;
                    if (bit_cnt == '0) begin
                        bit_cnt <= CNT_W'(ADDR_WIDTH - 1);
                        state   <= serial_bus_pkg::m_send_addr;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                serial_bus_pkg::m_send_addr: begin
                    bus_out <= hdr_sh[HDR_W-1];
                    hdr_sh  <= hdr_sh << 1;
                    if (bit_cnt == '0) begin
                        state <= serial_bus_pkg::m_wait_addr_ack;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                serial_bus_pkg::m_wait_addr_ack: begin
                    bus_out  <= 1'b1;
                    wait_cnt <= wait_cnt + 1'b1;
                    prev_low <= !bus_in;
                    if (ack_seen && op == serial_bus_pkg::op_write) begin
                        // first data bit goes out as the slave releases the line.
                        bus_out <= data_sh[DATA_WIDTH-1];
                        data_sh <= data_sh << 1;
                        bit_cnt <= CNT_W'(DATA_WIDTH - 2);
                        state   <= serial_bus_pkg::m_send_data;
                    end else if (ack_seen) begin
                        wait_cnt <= '0;
                        state    <= serial_bus_pkg::m_wait_read_start;
                    end else if (timeout) begin
                        nack  <= 1'b1;
                        state <= serial_bus_pkg::m_finish;
                    end
                end
                serial_bus_pkg::m_send_data: begin
                    bus_out <= data_sh[DATA_WIDTH-1];
                    data_sh <= data_sh << 1;
                    if (bit_cnt == '0) begin
                        state <= serial_bus_pkg::m_wait_data_ack;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                serial_bus_pkg::m_wait_data_ack: begin
                    bus_out  <= 1'b1;
                    wait_cnt <= wait_cnt + 1'b1;
                    prev_low <= !bus_in;
                    if (ack_seen) begin
                        state <= serial_bus_pkg::m_finish;
                    end else if (timeout) begin
                        nack  <= 1'b1;
                        state <= serial_bus_pkg::m_finish;
                    end
                end
                serial_bus_pkg::m_wait_read_start: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (!bus_in) begin
                        bit_cnt <= CNT_W'(DATA_WIDTH - 1);
                        state   <= serial_bus_pkg::m_receive_data;
                    end else if (timeout) begin
                        nack  <= 1'b1;
                        state <= serial_bus_pkg::m_finish;
                    end
                end
                serial_bus_pkg::m_receive_data: begin
                    data_sh <= {data_sh[DATA_WIDTH-2:0], bus_in};
                    if (bit_cnt == '0) begin
                        rdata <= {data_sh[DATA_WIDTH-2:0], bus_in};
                        state <= serial_bus_pkg::m_finish;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                serial_bus_pkg::m_finish: begin
                    done    <= 1'b1;
                    busy    <= 1'b0;
                    bus_req <= 1'b0;
                    state   <= serial_bus_pkg::m_idle;
                end
                default: state <= serial_bus_pkg::m_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) !grant |-> bus_out)
        else $error("bus_master: line pulled low without a grant");

endmodule

// ==== hw/bus_slave.sv ====
`timescale 1ns/1ps

module bus_slave #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 8,
    parameter logic [serial_bus_pkg::SLAVE_ID_WIDTH-1:0] SLAVE_ID = '0
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  bus_in,
    input  logic                  bus_util,
    input  logic                  mem_dv,
    input  logic [DATA_WIDTH-1:0] mem_rdata,
    output logic                  bus_out,
    output logic                  mem_we,
    output logic                  mem_re,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [DATA_WIDTH-1:0] mem_wdata
);

    localparam int SH_W  = (ADDR_WIDTH > DATA_WIDTH) ? ADDR_WIDTH : DATA_WIDTH;
    localparam int CNT_W = $clog2(SH_W + 1);
    localparam int ID_W  = serial_bus_pkg::SLAVE_ID_WIDTH;

    serial_bus_pkg::slave_state_e state;
    serial_bus_pkg::bus_op_e      op;
    logic [SH_W-1:0]  shift_reg;
    logic [CNT_W-1:0] bit_cnt;
    logic [1:0]       ack_cnt;
    logic             tx_on;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= serial_bus_pkg::s_idle;
            op      <= serial_bus_pkg::op_read;
            bus_out <= 1'b1;
            mem_we  <= 1'b0;
            mem_re  <= 1'b0;
            bit_cnt <= '0;
            ack_cnt <= '0;
            tx_on   <= 1'b0;
        end else begin
            mem_we <= 1'b0;
            mem_re <= 1'b0;
            case (state)
                serial_bus_pkg::s_idle: begin
                    if (!bus_in) begin
                        bit_cnt <= CNT_W'(ID_W);
                        state   <= serial_bus_pkg::s_id_match;
                    end
                end
                serial_bus_pkg::s_id_match: begin
                    shift_reg <= {shift_reg[SH_W-2:0], bus_in};
                    if (bit_cnt == '0) begin
                        // the id is in the shift register, the op bit is on the line.
                        op <= serial_bus_pkg::bus_op_e'(bus_in);
                        if (shift_reg[ID_W-1:0] == SLAVE_ID) begin
                            bit_cnt <= CNT_W'(ADDR_WIDTH - 1);
                            state   <= serial_bus_pkg::s_addr_rx;
                        end else begin
                            state <= serial_bus_pkg::s_wait_peer;
                        end
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                serial_bus_pkg::s_wait_peer: begin
                    if (!bus_util) begin
                        state <= serial_bus_pkg::s_idle;
                    end
                end
                serial_bus_pkg::s_addr_rx: begin
                    shift_reg <= {shift_reg[SH_W-2:0], bus_in};
                    if (bit_cnt == '0) begin
                        mem_addr <= {shift_reg[ADDR_WIDTH-2:0], bus_in};
                        ack_cnt  <= '0;
                        state    <= serial_bus_pkg::s_addr_ack;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                // one idle cycle, then two low cycles.
                serial_bus_pkg::s_addr_ack, serial_bus_pkg::s_data_ack: begin
                    ack_cnt <= ack_cnt + 1'b1;
                    if (ack_cnt == 2'd0) begin
                        bus_out <= 1'b0;
                    end else if (ack_cnt == 2'd2) begin
                        bus_out <= 1'b1;
                        ack_cnt <= '0;
                        if (state == serial_bus_pkg::s_data_ack) begin
                            mem_we <= 1'b1;
                            state  <= serial_bus_pkg::s_mem_write_wait;
                        end else if (op == serial_bus_pkg::op_write) begin
                            bit_cnt <= CNT_W'(DATA_WIDTH - 1);
                            state   <= serial_bus_pkg::s_data_rx;
                        end else begin
                            mem_re <= 1'b1;
                            state  <= serial_bus_pkg::s_mem_read_wait;
                        end
                    end
                end
                serial_bus_pkg::s_data_rx: begin
                    shift_reg <= {shift_reg[SH_W-2:0], bus_in};
                    if (bit_cnt == '0) begin
                        mem_wdata <= {shift_reg[DATA_WIDTH-2:0], bus_in};
                        ack_cnt   <= '0;
                        state     <= serial_bus_pkg::s_data_ack;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                serial_bus_pkg::s_mem_write_wait: begin
                    if (mem_dv) begin
                        state <= serial_bus_pkg::s_cleanup;
                    end
                end
                serial_bus_pkg::s_mem_read_wait: begin
                    if (mem_dv) begin
                        shift_reg <= SH_W'(mem_rdata);
                        tx_on     <= 1'b0;
                        state     <= serial_bus_pkg::s_data_tx;
                    end
                end
                serial_bus_pkg::s_data_tx: begin
                    if (!tx_on) begin
                        // start bit only once the line was seen high.
                        if (bus_in) begin
                            bus_out <= 1'b0;
                            tx_on   <= 1'b1;
                            bit_cnt <= CNT_W'(DATA_WIDTH - 1);
                        end
                    end else begin
                        bus_out   <= shift_reg[DATA_WIDTH-1];
                        shift_reg <= shift_reg << 1;
                        if (bit_cnt == '0) begin
                            state <= serial_bus_pkg::s_cleanup;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                serial_bus_pkg::s_cleanup: begin
                    bus_out <= 1'b1;
                    if (!bus_util) begin
                        state <= serial_bus_pkg::s_idle;
                    end
                end
                default: state <= serial_bus_pkg::s_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) !(mem_we && mem_re))
        else $error("bus_slave: write and read strobes together");

endmodule

// ==== hw/slave_memory.sv ====
`timescale 1ns/1ps

module slave_memory #(
    parameter int ADDR_WIDTH   = 6,
    parameter int DATA_WIDTH   = 8,
    parameter int READ_LATENCY = 1
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  mem_we,
    input  logic                  mem_re,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic [DATA_WIDTH-1:0] mem_wdata,
    output logic [DATA_WIDTH-1:0] mem_rdata,
    output logic                  mem_dv
);

    localparam int LAT_W = $clog2(READ_LATENCY + 1);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];
    logic [LAT_W-1:0]      lat_cnt;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        if (mem_re) begin
            mem_rdata <= mem[mem_addr];
        end
    end

    // dv one cycle after a write, READ_LATENCY cycles after a read.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_dv  <= 1'b0;
            lat_cnt <= '0;
        end else begin
            mem_dv <= 1'b0;
            if (mem_we || (mem_re && READ_LATENCY == 1)) begin
                mem_dv <= 1'b1;
            end else if (mem_re) begin
                lat_cnt <= LAT_W'(READ_LATENCY - 1);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
                mem_dv  <= lat_cnt == LAT_W'(1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) lat_cnt != '0 |-> !(mem_we || mem_re))
        else $error("slave_memory: new strobe while a read is pending");

endmodule

// ==== hw/serial_bus_top.sv ====
`timescale 1ns/1ps

module serial_bus_top #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 8
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      m0_req,
    input  logic                                      m0_req_write,
    input  logic [serial_bus_pkg::SLAVE_ID_WIDTH-1:0] m0_req_slave_id,
    input  logic [ADDR_WIDTH-1:0]                     m0_req_addr,
    input  logic [DATA_WIDTH-1:0]                     m0_req_wdata,
    output logic                                      m0_busy,
    output logic                                      m0_done,
    output logic [DATA_WIDTH-1:0]                     m0_rdata,
    output logic                                      m0_nack,
    input  logic                                      m1_req,
    input  logic                                      m1_req_write,
    input  logic [serial_bus_pkg::SLAVE_ID_WIDTH-1:0] m1_req_slave_id,
    input  logic [ADDR_WIDTH-1:0]                     m1_req_addr,
    input  logic [DATA_WIDTH-1:0]                     m1_req_wdata,
    output logic                                      m1_busy,
    output logic                                      m1_done,
    output logic [DATA_WIDTH-1:0]                     m1_rdata,
    output logic                                      m1_nack
);

    logic [1:0] bus_req;
    logic [1:0] grant;
    logic       bus_util;
    logic       bus_line;
    // drivers 0 and 1 are the masters, 2 and 3 the slaves.
    logic [3:0] drv;

    assign bus_line = &drv;

    bus_arbiter u_arbiter (
        .clk(clk), .rstn(rstn), .bus_req(bus_req), .grant(grant), .bus_util(bus_util)
    );

    bus_master #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_master0 (
        .clk(clk), .rstn(rstn), .req(m0_req), .req_write(m0_req_write),
        .req_slave_id(m0_req_slave_id), .req_addr(m0_req_addr), .req_wdata(m0_req_wdata),
        .grant(grant[0]), .bus_in(bus_line), .busy(m0_busy), .bus_req(bus_req[0]),
        .bus_out(drv[0]), .done(m0_done), .rdata(m0_rdata), .nack(m0_nack)
    );

    bus_master #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_master1 (
        .clk(clk), .rstn(rstn), .req(m1_req), .req_write(m1_req_write),
        .req_slave_id(m1_req_slave_id), .req_addr(m1_req_addr), .req_wdata(m1_req_wdata),
        .grant(grant[1]), .bus_in(bus_line), .busy(m1_busy), .bus_req(bus_req[1]),
        .bus_out(drv[1]), .done(m1_done), .rdata(m1_rdata), .nack(m1_nack)
    );

    for (genvar i = 0; i < 2; i++) begin : g_slave
        logic                  mem_we;
        logic                  mem_re;
        logic                  mem_dv;
        logic [ADDR_WIDTH-1:0] mem_addr;
        logic [DATA_WIDTH-1:0] mem_wdata;
        logic [DATA_WIDTH-1:0] mem_rdata;

        bus_slave #(
            .ADDR_WIDTH(ADDR_WIDTH),
            .DATA_WIDTH(DATA_WIDTH),
            .SLAVE_ID(serial_bus_pkg::SLAVE_ID_WIDTH'(i))
        ) u_slave (
            .clk(clk), .rstn(rstn), .bus_in(bus_line), .bus_util(bus_util),
            .mem_dv(mem_dv), .mem_rdata(mem_rdata), .bus_out(drv[2+i]),
            .mem_we(mem_we), .mem_re(mem_re), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
        );

        // slave 1 has the slower memory.
        slave_memory #(
            .ADDR_WIDTH(ADDR_WIDTH),
            .DATA_WIDTH(DATA_WIDTH),
            .READ_LATENCY((i == 0) ? 1 : 3)
        ) u_memory (
            .clk(clk), .rstn(rstn), .mem_we(mem_we), .mem_re(mem_re),
            .mem_addr(mem_addr), .mem_wdata(mem_wdata),
            .mem_rdata(mem_rdata), .mem_dv(mem_dv)
        );
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset is held for ten rising edges.
    initial begin
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== tb/tb_serial_bus.sv ====
`timescale 1ns/1ps

module tb_serial_bus;

    localparam int ADDR_WIDTH  = 6;
    localparam int DATA_WIDTH  = 8;
    localparam int ID_W        = serial_bus_pkg::SLAVE_ID_WIDTH;
    localparam int DEPTH       = 2 ** ADDR_WIDTH;
    // start, id, op and address, then a start bit and the data word.
    localparam int FRAME_LEN   = 1 + ID_W + 1 + ADDR_WIDTH + 1 + DATA_WIDTH;
    localparam int OP_CYCLES   = 2 * (FRAME_LEN + serial_bus_pkg::ACK_WINDOW + 8);
    localparam int RAND_OPS    = 40;
    localparam int NUM_OPS     = 1 + 16 + 4 + 8 + RAND_OPS;
    localparam int WATCHDOG_NS = (NUM_OPS * OP_CYCLES + 20) * 20;

    logic                  clk;
    logic                  rstn;
    logic                  m0_req;
    logic                  m0_req_write;
    logic [ID_W-1:0]       m0_req_slave_id;
    logic [ADDR_WIDTH-1:0] m0_req_addr;
    logic [DATA_WIDTH-1:0] m0_req_wdata;
    logic                  m0_busy;
    logic                  m0_done;
    logic [DATA_WIDTH-1:0] m0_rdata;
    logic                  m0_nack;
    logic                  m1_req;
    logic                  m1_req_write;
    logic [ID_W-1:0]       m1_req_slave_id;
    logic [ADDR_WIDTH-1:0] m1_req_addr;
    logic [DATA_WIDTH-1:0] m1_req_wdata;
    logic                  m1_busy;
    logic                  m1_done;
    logic [DATA_WIDTH-1:0] m1_rdata;
    logic                  m1_nack;

    // one reference word array per slave id.
    logic [DATA_WIDTH-1:0] ref_mem [2][DEPTH];
    bit                    written [2][DEPTH];

    // request in flight per master and what came back with done.
    bit                    op_wr     [2];
    int                    op_sid    [2];
    int                    op_addr   [2];
    logic [DATA_WIDTH-1:0] op_data   [2];
    bit                    res_seen  [2];
    logic [DATA_WIDTH-1:0] res_rdata [2];
    logic                  res_nack  [2];
    bit                    res_busy  [2];
    bit                    busy_gap  [2];

    int errors;
    int checks;

    tb_clock_gen u_clk (.clk(clk), .rstn(rstn));

    serial_bus_top #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) dut0 (
        .clk(clk), .rstn(rstn),
        .m0_req(m0_req), .m0_req_write(m0_req_write), .m0_req_slave_id(m0_req_slave_id),
        .m0_req_addr(m0_req_addr), .m0_req_wdata(m0_req_wdata), .m0_busy(m0_busy),
        .m0_done(m0_done), .m0_rdata(m0_rdata), .m0_nack(m0_nack),
        .m1_req(m1_req), .m1_req_write(m1_req_write), .m1_req_slave_id(m1_req_slave_id),
        .m1_req_addr(m1_req_addr), .m1_req_wdata(m1_req_wdata), .m1_busy(m1_busy),
        .m1_done(m1_done), .m1_rdata(m1_rdata), .m1_nack(m1_nack)
    );

    task automatic set_req(input int m, input bit wr, input int sid, input int addr,
                           input logic [DATA_WIDTH-1:0] wdata);
        op_wr[m]   = wr;
        op_sid[m]  = sid;
        op_addr[m] = addr;
        op_data[m] = wdata;
        if (m == 0) begin
            m0_req          <= 1'b1;
            m0_req_write    <= wr;
            m0_req_slave_id <= ID_W'(sid);
            m0_req_addr     <= ADDR_WIDTH'(addr);
            m0_req_wdata    <= wdata;
        end else begin
            m1_req          <= 1'b1;
            m1_req_write    <= wr;
            m1_req_slave_id <= ID_W'(sid);
            m1_req_addr     <= ADDR_WIDTH'(addr);
            m1_req_wdata    <= wdata;
        end
    endtask

    task automatic clear_reqs();
        m0_req <= 1'b0;
        m1_req <= 1'b0;
    endtask

    task automatic wait_done(input bit want0, input bit want1);
        int cycles;
        cycles      = 0;
        res_seen[0] = !want0;
        res_seen[1] = !want1;
        busy_gap[0] = 1'b0;
        busy_gap[1] = 1'b0;
        while (!(res_seen[0] && res_seen[1]) && cycles < 2 * OP_CYCLES) begin
            @(negedge clk);
            cycles++;
            // busy covers a request from acceptance until done.
            if (!res_seen[0] && !m0_done && !m0_busy) begin
                busy_gap[0] = 1'b1;
            end
            if (!res_seen[1] && !m1_done && !m1_busy) begin
                busy_gap[1] = 1'b1;
            end
            if (m0_done) begin
                res_seen[0]  = 1'b1;
                res_busy[0]  = m0_busy;
                res_rdata[0] = m0_rdata;
                res_nack[0]  = m0_nack;
            end
            if (m1_done) begin
                res_seen[1]  = 1'b1;
                res_busy[1]  = m1_busy;
                res_rdata[1] = m1_rdata;
                res_nack[1]  = m1_nack;
            end
        end
        if (!(res_seen[0] && res_seen[1])) begin
            errors++;
            $display("timeout at %0t: a master gave no done within %0d cycles",
                     $time, 2 * OP_CYCLES);
        end
    endtask

    // ids above 1 have no slave and must end in a nack.
    task automatic check_result(input int m);
        int sid;
        int addr;
        bit exp_nack;
        sid      = op_sid[m];
        addr     = op_addr[m];
        exp_nack = sid > 1;
        if (res_seen[m]) begin
            checks++;
            assert (res_nack[m] == exp_nack) else begin
                errors++;
                $display("[FAIL] %0t: master %0d slave %0d addr %0d nack %0b, expected %0b",
                         $time, m, sid, addr, res_nack[m], exp_nack);
            end
            checks++;
            assert (!busy_gap[m] && !res_busy[m]) else begin
                errors++;
                $display("[FAIL] %0t: master %0d busy not high from acceptance until done",
                         $time, m);
            end
            if (!exp_nack && op_wr[m]) begin
                ref_mem[sid][addr] = op_data[m];
                written[sid][addr] = 1'b1;
            end else if (!exp_nack) begin
                checks++;
                assert (res_rdata[m] === ref_mem[sid][addr]) else begin
                    errors++;
                    $display("[FAIL] %0t: master %0d slave %0d addr %0d read %h, expected %h",
                             $time, m, sid, addr, res_rdata[m], ref_mem[sid][addr]);
                end
            end
        end
    endtask

    task automatic run_op(input int m, input bit wr, input int sid, input int addr,
                          input logic [DATA_WIDTH-1:0] wdata);
        @(posedge clk);
        set_req(m, wr, sid, addr, wdata);
        @(posedge clk);
        clear_reqs();
        wait_done(m == 0, m == 1);
        check_result(m);
    endtask

    task automatic run_pair(input bit wr0, input int sid0, input int addr0,
                            input logic [DATA_WIDTH-1:0] data0,
                            input bit wr1, input int sid1, input int addr1,
                            input logic [DATA_WIDTH-1:0] data1);
        @(posedge clk);
        set_req(0, wr0, sid0, addr0, data0);
        set_req(1, wr1, sid1, addr1, data1);
        @(posedge clk);
        clear_reqs();
        wait_done(1'b1, 1'b1);
        check_result(0);
        check_result(1);
    endtask

    // reads only hit written words, and never the other master's target.
    task automatic pick_op(output bit wr, output int sid, output int addr,
                           input int avoid_sid, input int avoid_addr);
        wr  = 1'($urandom_range(1, 0));
        sid = int'($urandom_range(1, 0));
        do begin
            addr = int'($urandom_range(DEPTH - 1, 0));
        end while ((!wr && !written[sid][addr]) || (sid == avoid_sid && addr == avoid_addr));
    endtask

    task automatic verify_reset();
        @(negedge clk);
        checks++;
        assert ({m0_busy, m0_done, m0_nack, m1_busy, m1_done, m1_nack} == 6'b0) else begin
            errors++;
            $display("[FAIL] %0t: busy, done or nack not low after reset", $time);
        end
        run_op(0, 1'b1, 0, 5, 8'h3c);
    endtask

    task automatic write_then_read();
        int addrs [4];
        addrs = '{0, 17, 63, 17};
        for (int sid = 0; sid < 2; sid++) begin
            foreach (addrs[i]) begin
                run_op(0, 1'b1, sid, addrs[i], DATA_WIDTH'($urandom));
            end
            foreach (addrs[i]) begin
                run_op(0, 1'b0, sid, addrs[i], '0);
            end
        end
    endtask

    task automatic probe_missing_ids();
        run_op(0, 1'b0, 2, 3, '0);
        run_op(1, 1'b1, 3, 9, 8'h5a);
        run_op(0, 1'b1, 1, 9, 8'ha5);
        run_op(0, 1'b0, 1, 9, '0);
    endtask

    task automatic contend_two_masters();
        run_pair(1'b1, 0, 20, 8'h11, 1'b1, 1, 20, 8'h22);
        run_pair(1'b0, 0, 20, '0, 1'b0, 1, 20, '0);
        run_pair(1'b1, 1, 30, 8'h33, 1'b1, 1, 31, 8'h44);
        run_pair(1'b0, 1, 30, '0, 1'b0, 1, 31, '0);
    endtask

    task automatic random_traffic();
        bit wr0;
        bit wr1;
        int sid0;
        int sid1;
        int addr0;
        int addr1;
        for (int i = 0; i < RAND_OPS / 2; i++) begin
            pick_op(wr0, sid0, addr0, -1, -1);
            pick_op(wr1, sid1, addr1, sid0, addr0);
            run_pair(wr0, sid0, addr0, DATA_WIDTH'($urandom),
                     wr1, sid1, addr1, DATA_WIDTH'($urandom));
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("watchdog: run exceeded %0d ns, the bus appears to hang", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        m0_req          = 1'b0;
        m0_req_write    = 1'b0;
        m0_req_slave_id = '0;
        m0_req_addr     = '0;
        m0_req_wdata    = '0;
        m1_req          = 1'b0;
        m1_req_write    = 1'b0;
        m1_req_slave_id = '0;
        m1_req_addr     = '0;
        m1_req_wdata    = '0;
        errors          = 0;
        checks          = 0;
        void'($urandom(73879));
        @(posedge rstn);
        verify_reset();
        write_then_read();
        probe_missing_ids();
        contend_two_masters();
        random_traffic();
        repeat (5) @(posedge clk);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/serial_bus_pkg.sv
hw/bus_arbiter.sv
hw/bus_master.sv
hw/bus_slave.sv
hw/slave_memory.sv
hw/serial_bus_top.sv
tb/tb_clock_gen.sv
tb/tb_serial_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_bus \
    -f all.f -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb 2>&1 | tee sim.log
grep -q '^\*\* PASS \*\*$' sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
